//--- src/memPkg.sv
`default_nettype none

package memPkg;

	// Memory geometry
	// Byte lanes in one word
	localparam int ByteCount = 4;

	// Data width follows the lane count
	localparam int WordSize = 8 * ByteCount;

	// Word address, 512 words deep
	localparam int AddressSize = 9;
	localparam int MemWords = 2 ** AddressSize;

	// Arbiter grant states
	// Idle means neither master owns the memory port
	localparam logic [1:0] GrantIdle = 2'b00;
	localparam logic [1:0] GrantHost = 2'b01;
	localparam logic [1:0] GrantData = 2'b10;

endpackage

`default_nettype wire

//--- src/wishboneIf.sv
`timescale 1ns/1ps
`default_nettype none

interface wishboneIf;
	import memPkg::*;

	// Master to slave
	logic cyc;
	logic stb;
	logic we;
	logic [ByteCount-1:0] sel;
	logic [AddressSize-1:0] adr;
	logic [WordSize-1:0] datW;

	// Slave to master
	logic [WordSize-1:0] datR;
	logic ack;

	modport master (
		output cyc, stb, we, sel, adr, datW,
		input datR, ack
	);

	modport slave (
		input cyc, stb, we, sel, adr, datW,
		output datR, ack
	);

	// Read-only slave for the fetch path
	modport readSlave (
		input cyc, stb, adr,
		output datR, ack
	);

endinterface

`default_nettype wire

//--- src/wbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbArbiter (
	input logic clk0,
	input logic arstN,
	wishboneIf.slave hostSide,
	wishboneIf.slave dataSide,
	wishboneIf.master memSide
);
	import memPkg::*;

	logic [1:0] grant;
	// Set when data won the most recent tie
	logic lastData;

	logic hostReq;
	logic dataReq;
	logic hostGranted;
	logic dataGranted;

	assign hostReq = hostSide.cyc && hostSide.stb;
	assign dataReq = dataSide.cyc && dataSide.stb;
	assign hostGranted = grant == GrantHost;
	assign dataGranted = grant == GrantData;

	// Grant FSM
	// The tie record only flips on a contested grant
	always_ff @(posedge clk0 or negedge arstN) begin
		if (!arstN) begin
			grant <= GrantIdle;
			lastData <= 1'b1;
		end else begin
			case (grant)
				GrantIdle: begin
					if (hostReq && dataReq) begin
						grant <= lastData ? GrantHost : GrantData;
						lastData <= !lastData;
					end else if (hostReq) begin
						grant <= GrantHost;
					end else if (dataReq) begin
						grant <= GrantData;
					end
				end
				GrantHost: begin
					// Held until the host closes its cycle
					if (!hostSide.cyc) begin
						grant <= GrantIdle;
					end
				end
				GrantData: begin
					if (!dataSide.cyc) begin
						grant <= GrantIdle;
					end
				end
				default: begin
					grant <= GrantIdle;
				end
			endcase
		end
	end

	// Only the owner's cycle reaches the memory
	assign memSide.cyc = (hostGranted && hostSide.cyc) || (dataGranted && dataSide.cyc);
	assign memSide.stb = (hostGranted && hostSide.stb) || (dataGranted && dataSide.stb);

	// Payload steering, host by default
	always_comb begin
		if (dataGranted) begin
			memSide.we = dataSide.we;
			memSide.sel = dataSide.sel;
			memSide.adr = dataSide.adr;
			memSide.datW = dataSide.datW;
		end else begin
			memSide.we = hostSide.we;
			memSide.sel = hostSide.sel;
			memSide.adr = hostSide.adr;
			memSide.datW = hostSide.datW;
		end
	end

	// Read data is shared, ack goes to the owner only
	assign hostSide.datR = memSide.datR;
	assign dataSide.datR = memSide.datR;
	assign hostSide.ack = hostGranted && memSide.ack;
	assign dataSide.ack = dataGranted && memSide.ack;

	// Ownership is stable for the whole bus cycle
	hostGrantHeld: assert property (@(posedge clk0) disable iff (!arstN)
		hostGranted && hostSide.cyc |=> hostGranted);

	dataGrantHeld: assert property (@(posedge clk0) disable iff (!arstN)
		dataGranted && dataSide.cyc |=> dataGranted);

	// Memory ack must land on a master that still holds its cycle
	hostAckInCycle: assert property (@(posedge clk0) disable iff (!arstN)
		hostSide.ack |-> hostSide.cyc);

	dataAckInCycle: assert property (@(posedge clk0) disable iff (!arstN)
		dataSide.ack |-> dataSide.cyc);

endmodule

`default_nettype wire

//--- src/sramDualPort.sv
`timescale 1ns/1ps
`default_nettype none

module sramDualPort (
	input logic clk0,
	input logic arstN,
	wishboneIf.slave primary,
	wishboneIf.readSlave secondary
);
	import memPkg::*;

	logic [WordSize-1:0] memory [MemWords];

	// Primary read/write port request
	logic priSel;
	logic priWe;
	logic [ByteCount-1:0] priMask;
	logic [AddressSize-1:0] priAdr;
	logic [WordSize-1:0] priDatW;

	// Secondary read port request
	logic secSel;
	logic [AddressSize-1:0] secAdr;

	logic priAccept;
	logic secAccept;

	// New access only while our own ack is low
	assign priAccept = primary.cyc && primary.stb && !primary.ack;
	assign secAccept = secondary.cyc && secondary.stb && !secondary.ack;

	// Selects double as the registered acks
	always_ff @(posedge clk0 or negedge arstN) begin
		if (!arstN) begin
			priSel <= 1'b0;
			secSel <= 1'b0;
		end else begin
			priSel <= priAccept;
			secSel <= secAccept;
		end
	end

	// Request payload, captured at the accepting edge
	always_ff @(posedge clk0) begin
		if (priAccept) begin
			priWe <= primary.we;
			priMask <= primary.sel;
			priAdr <= primary.adr;
			priDatW <= primary.datW;
		end
		if (secAccept) begin
			secAdr <= secondary.adr;
		end
	end

	assign primary.ack = priSel;
	assign secondary.ack = secSel;

	// Masked write in the middle of the ack cycle
	always_ff @(negedge clk0) begin
		if (priSel && priWe) begin
			for (int i = 0; i < ByteCount; i++) begin
				if (priMask[i]) begin
					memory[priAdr][i*8 +: 8] <= priDatW[i*8 +: 8];
				end
			end
		end
	end

	// Reads on the same edge see the word before any write there
	always_ff @(negedge clk0) begin
		if (priSel && !priWe) begin
			primary.datR <= memory[priAdr];
		end
		if (secSel) begin
			secondary.datR <= memory[secAdr];
		end
	end

	// Ack only follows a request sampled one edge earlier
	priAckFollowsReq: assert property (@(posedge clk0) disable iff (!arstN)
		primary.ack |-> $past(primary.cyc && primary.stb));

	secAckFollowsReq: assert property (@(posedge clk0) disable iff (!arstN)
		secondary.ack |-> $past(secondary.cyc && secondary.stb));

	// Single-cycle ack on both ports
	priAckPulse: assert property (@(posedge clk0) disable iff (!arstN)
		primary.ack |=> !primary.ack);

	secAckPulse: assert property (@(posedge clk0) disable iff (!arstN)
		secondary.ack |=> !secondary.ack);

endmodule

`default_nettype wire

//--- src/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
	input logic clk0,
	input logic arstN,

	// Host (management) bus
	input logic hostCyc,
	input logic hostStb,
	input logic hostWe,
	input logic [memPkg::ByteCount-1:0] hostSel,
	input logic [memPkg::AddressSize-1:0] hostAdr,
	input logic [memPkg::WordSize-1:0] hostDatW,
	output logic [memPkg::WordSize-1:0] hostDatR,
	output logic hostAck,

	// Processor data bus
	input logic dataCyc,
	input logic dataStb,
	input logic dataWe,
	input logic [memPkg::ByteCount-1:0] dataSel,
	input logic [memPkg::AddressSize-1:0] dataAdr,
	input logic [memPkg::WordSize-1:0] dataDatW,
	output logic [memPkg::WordSize-1:0] dataDatR,
	output logic dataAck,

	// Instruction fetch bus, read only
	input logic fetchCyc,
	input logic fetchStb,
	input logic [memPkg::AddressSize-1:0] fetchAdr,
	output logic [memPkg::WordSize-1:0] fetchDatR,
	output logic fetchAck
);

	wishboneIf hostBus ();
	wishboneIf dataBus ();
	wishboneIf memBus ();
	wishboneIf fetchBus ();

	assign hostBus.cyc = hostCyc;
	assign hostBus.stb = hostStb;
	assign hostBus.we = hostWe;
	assign hostBus.sel = hostSel;
	assign hostBus.adr = hostAdr;
	assign hostBus.datW = hostDatW;
	assign hostDatR = hostBus.datR;
	assign hostAck = hostBus.ack;

	assign dataBus.cyc = dataCyc;
	assign dataBus.stb = dataStb;
	assign dataBus.we = dataWe;
	assign dataBus.sel = dataSel;
	assign dataBus.adr = dataAdr;
	assign dataBus.datW = dataDatW;
	assign dataDatR = dataBus.datR;
	assign dataAck = dataBus.ack;

	// Fetch path has no write side
	assign fetchBus.cyc = fetchCyc;
	assign fetchBus.stb = fetchStb;
	assign fetchBus.adr = fetchAdr;
	assign fetchDatR = fetchBus.datR;
	assign fetchAck = fetchBus.ack;

	// Host and data share the read/write port
	wbArbiter arbiter0 (
		.clk0(clk0),
		.arstN(arstN),
		.hostSide(hostBus.slave),
		.dataSide(dataBus.slave),
		.memSide(memBus.master)
	);

	sramDualPort sram0 (
		.clk0(clk0),
		.arstN(arstN),
		.primary(memBus.slave),
		.secondary(fetchBus.readSlave)
	);

endmodule

`default_nettype wire

//--- sim/memVectors.svh
`ifndef MEMVECTORS_SVH
`define MEMVECTORS_SVH

`default_nettype none

localparam int NumVectors = 21;
localparam int NameChars = 12;

// Which bus a row runs on
localparam logic [1:0] BusHost = 2'd0;
localparam logic [1:0] BusData = 2'd1;
localparam logic [1:0] BusFetch = 2'd2;
localparam logic [1:0] BusBoth = 2'd3;

typedef struct packed {
	logic [8*NameChars-1:0] name;
	logic [1:0] bus;
	logic we;
	logic [ByteCount-1:0] sel;
	logic [AddressSize-1:0] adr;
	logic [WordSize-1:0] datW;
	logic [WordSize-1:0] expData;
} vecRow;

// Columns: name, bus, write enable, byte mask, word address, write data, expected read word
// Expected words follow the byte-mask rule applied to the earlier writes
localparam vecRow Vectors [NumVectors] = '{
	// Full-mask write and read back on both writable buses
	'{"hostFullWr  ", BusHost, 1'b1, 4'hF, 9'h010, 32'h11223344, 32'h00000000},
	'{"hostFullRd  ", BusHost, 1'b0, 4'hF, 9'h010, 32'h00000000, 32'h11223344},
	'{"dataFullWr  ", BusData, 1'b1, 4'hF, 9'h020, 32'hA5A55A5A, 32'h00000000},
	'{"dataFullRd  ", BusData, 1'b0, 4'hF, 9'h020, 32'h00000000, 32'hA5A55A5A},
	'{"hostRdData  ", BusHost, 1'b0, 4'hF, 9'h020, 32'h00000000, 32'hA5A55A5A},
	// Partial masks keep the unselected bytes
	'{"hostPartWr  ", BusHost, 1'b1, 4'h5, 9'h010, 32'hAABBCCDD, 32'h00000000},
	'{"hostPartRd  ", BusHost, 1'b0, 4'hF, 9'h010, 32'h00000000, 32'h11BB33DD},
	'{"dataPartWr  ", BusData, 1'b1, 4'h8, 9'h020, 32'h7E123456, 32'h00000000},
	'{"dataPartRd  ", BusData, 1'b0, 4'hF, 9'h020, 32'h00000000, 32'h7EA55A5A},
	'{"dataPartWr2 ", BusData, 1'b1, 4'h3, 9'h010, 32'hFFFF0F0F, 32'h00000000},
	// Fetch port sees words from either writer
	'{"fetchRdLow  ", BusFetch, 1'b0, 4'hF, 9'h010, 32'h00000000, 32'h11BB0F0F},
	'{"fetchRdMid  ", BusFetch, 1'b0, 4'hF, 9'h020, 32'h00000000, 32'h7EA55A5A},
	'{"hostWrTop   ", BusHost, 1'b1, 4'hF, 9'h1FF, 32'hDEADBEEF, 32'h00000000},
	'{"fetchRdTop  ", BusFetch, 1'b0, 4'hF, 9'h1FF, 32'h00000000, 32'hDEADBEEF},
	'{"dataWrZero  ", BusData, 1'b1, 4'hF, 9'h000, 32'h0BADF00D, 32'h00000000},
	'{"fetchRdZero ", BusFetch, 1'b0, 4'hF, 9'h000, 32'h00000000, 32'h0BADF00D},
	// Host and data start together, tie winner alternates
	'{"bothTie1    ", BusBoth, 1'b0, 4'hF, 9'h010, 32'h00000000, 32'h11BB0F0F},
	'{"bothTie2    ", BusBoth, 1'b0, 4'hF, 9'h1FF, 32'h00000000, 32'hDEADBEEF},
	'{"bothTie3    ", BusBoth, 1'b0, 4'hF, 9'h000, 32'h00000000, 32'h0BADF00D},
	'{"hostPartTop ", BusHost, 1'b1, 4'hA, 9'h1FF, 32'h01020304, 32'h00000000},
	'{"fetchRdMix  ", BusFetch, 1'b0, 4'hF, 9'h1FF, 32'h00000000, 32'h01AD03EF}
};

`default_nettype wire

`endif

//--- sim/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;
	import memPkg::*;

	`include "memVectors.svh"

	localparam int ClockPeriod = 10;
	localparam int ResetCycles = 10;
	localparam int RandomCount = 12;
	// 20 cycles per access, each random item makes three
	localparam int CycleLimit = ResetCycles + 20 * (NumVectors + 3 * RandomCount + 1);

	logic clk0;
	logic arstN;
	logic hostCyc, hostStb, hostWe, hostAck;
	logic [ByteCount-1:0] hostSel;
	logic [AddressSize-1:0] hostAdr;
	logic [WordSize-1:0] hostDatW, hostDatR;
	logic dataCyc, dataStb, dataWe, dataAck;
	logic [ByteCount-1:0] dataSel;
	logic [AddressSize-1:0] dataAdr;
	logic [WordSize-1:0] dataDatW, dataDatR;
	logic fetchCyc, fetchStb, fetchAck;
	logic [AddressSize-1:0] fetchAdr;
	logic [WordSize-1:0] fetchDatR;

	// Reference memory
	logic [WordSize-1:0] refMem [MemWords];
	int errorCount;
	int checkCount;
	int cycleCount;
	int seed;

	memSubsystem dut0 (.*);

	initial begin
		clk0 = 1'b0;
		forever #(ClockPeriod / 2) clk0 = ~clk0;
	end

	// Watchdog
	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge clk0);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
		$display("Test failures found");
		$finish;
	end

	// Byte-mask rule
	function automatic void modelWrite(input logic [ByteCount-1:0] sel,
			input logic [AddressSize-1:0] adr, input logic [WordSize-1:0] datW);
		for (int b = 0; b < ByteCount; b++) begin
			if (sel[b]) begin
				refMem[adr][b*8 +: 8] = datW[b*8 +: 8];
			end
		end
	endfunction

	task automatic checkWord(input logic [8*NameChars-1:0] name,
			input logic [WordSize-1:0] expWord, input logic [WordSize-1:0] gotWord);
		checkCount++;
		assert (gotWord === expWord) else begin
			$display("** Error %s: expected %h, actual %h", name, expWord, gotWord);
			errorCount++;
		end
	endtask

	task automatic checkIdle();
		checkCount++;
		assert (!hostAck && !dataAck && !fetchAck) else begin
			$display("An ack was raised with no request pending at cycle %0d", cycleCount);
			errorCount++;
		end
	endtask

	task automatic hostAccess(input logic we, input logic [ByteCount-1:0] sel,
			input logic [AddressSize-1:0] adr, input logic [WordSize-1:0] datW,
			output logic [WordSize-1:0] datR, output int ackCycle);
		@(negedge clk0);
		hostCyc = 1'b1;
		hostStb = 1'b1;
		hostWe = we;
		hostSel = sel;
		hostAdr = adr;
		hostDatW = datW;
		@(negedge clk0);
		while (hostAck !== 1'b1) begin
			@(negedge clk0);
		end
		ackCycle = cycleCount;
		// Request stays up through the edge that samples ack
		@(negedge clk0);
		hostCyc = 1'b0;
		hostStb = 1'b0;
		hostWe = 1'b0;
		// Read data settled on the falling edge of the ack cycle
		datR = hostDatR;
	endtask

	task automatic dataAccess(input logic we, input logic [ByteCount-1:0] sel,
			input logic [AddressSize-1:0] adr, input logic [WordSize-1:0] datW,
			output logic [WordSize-1:0] datR, output int ackCycle);
		@(negedge clk0);
		dataCyc = 1'b1;
		dataStb = 1'b1;
		dataWe = we;
		dataSel = sel;
		dataAdr = adr;
		dataDatW = datW;
		@(negedge clk0);
		while (dataAck !== 1'b1) begin
			@(negedge clk0);
		end
		ackCycle = cycleCount;
		@(negedge clk0);
		dataCyc = 1'b0;
		dataStb = 1'b0;
		dataWe = 1'b0;
		datR = dataDatR;
	endtask

	task automatic fetchRead(input logic [8*NameChars-1:0] name,
			input logic [AddressSize-1:0] adr, output logic [WordSize-1:0] datR);
		@(negedge clk0);
		fetchCyc = 1'b1;
		fetchStb = 1'b1;
		fetchAdr = adr;
		// Fetch ack is due exactly one cycle later
		@(negedge clk0);
		checkCount++;
		assert (fetchAck === 1'b1) else begin
			$display("Fetch ack did not arrive one cycle after the request in %s", name);
			errorCount++;
		end
		while (fetchAck !== 1'b1) begin
			@(negedge clk0);
		end
		@(negedge clk0);
		fetchCyc = 1'b0;
		fetchStb = 1'b0;
		datR = fetchDatR;
	endtask

	initial begin
		vecRow row;
		logic [WordSize-1:0] got;
		logic [WordSize-1:0] gotData;
		logic [WordSize-1:0] rnd;
		logic [AddressSize-1:0] rAdr;
		logic [ByteCount-1:0] rSel;
		int hostCycle;
		int dataCycle;
		bit hostWinsTie;

		errorCount = 0;
		checkCount = 0;
		seed = 68;
		hostWinsTie = 1'b1;
		arstN = 1'b0;
		hostCyc = 1'b0;
		hostStb = 1'b0;
		hostWe = 1'b0;
		hostSel = '0;
		hostAdr = '0;
		hostDatW = '0;
		dataCyc = 1'b0;
		dataStb = 1'b0;
		dataWe = 1'b0;
		dataSel = '0;
		dataAdr = '0;
		dataDatW = '0;
		fetchCyc = 1'b0;
		fetchStb = 1'b0;
		fetchAdr = '0;

		repeat (ResetCycles) begin
			@(negedge clk0);
			checkIdle();
		end
		arstN = 1'b1;
		repeat (3) begin
			@(negedge clk0);
			checkIdle();
		end

		for (int i = 0; i < NumVectors; i++) begin
			row = Vectors[i];
			case (row.bus)
				BusHost: hostAccess(row.we, row.sel, row.adr, row.datW, got, hostCycle);
				BusData: dataAccess(row.we, row.sel, row.adr, row.datW, got, dataCycle);
				BusFetch: fetchRead(row.name, row.adr, got);
				default: begin
					fork
						hostAccess(1'b0, '1, row.adr, '0, got, hostCycle);
						dataAccess(1'b0, '1, row.adr, '0, gotData, dataCycle);
					join
					checkWord(row.name, row.expData, gotData);
					checkCount++;
					assert ((hostCycle < dataCycle) == hostWinsTie) else begin
						$display("The wrong master was acknowledged first in %s", row.name);
						errorCount++;
					end
					hostWinsTie = !hostWinsTie;
				end
			endcase
			if (row.we) begin
				modelWrite(row.sel, row.adr, row.datW);
			end else begin
				checkWord(row.name, row.expData, got);
				checkCount++;
				assert (refMem[row.adr] === row.expData) else begin
					$display("Table row %s disagrees with the reference model", row.name);
					errorCount++;
				end
			end
		end

		// Full write, masked write from the other master, fetch read back
		for (int j = 0; j < RandomCount; j++) begin
			rnd = $random(seed);
			rAdr = rnd[AddressSize-1:0];
			rnd = $random(seed);
			if (j % 2 == 0) begin
				hostAccess(1'b1, '1, rAdr, rnd, got, hostCycle);
			end else begin
				dataAccess(1'b1, '1, rAdr, rnd, got, dataCycle);
			end
			modelWrite('1, rAdr, rnd);
			rnd = $random(seed);
			rSel = rnd[ByteCount-1:0];
			rnd = $random(seed);
			if (j % 2 == 0) begin
				dataAccess(1'b1, rSel, rAdr, rnd, got, dataCycle);
			end else begin
				hostAccess(1'b1, rSel, rAdr, rnd, got, hostCycle);
			end
			modelWrite(rSel, rAdr, rnd);
			fetchRead("randomFetch ", rAdr, got);
			checkWord("randomFetch ", refMem[rAdr], got);
		end

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
src/memPkg.sv
src/wishboneIf.sv
src/wbArbiter.sv
src/sramDualPort.sv
src/memSubsystem.sv
sim/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module memSubsystemTb -f build.f \
	-o memSubsystemTbSim > build.log 2>&1 \
	&& ./obj_dir/memSubsystemTbSim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
